// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := pease_fft_tb
FILE_LIST := list.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)

// File: design/butterfly_bank.sv
`timescale 1ns/1ps

module butterfly_bank (
  input  fft_pkg::cplx_frame_t  data,
  input  fft_pkg::twiddle_set_t twiddles,
  output fft_pkg::cplx_frame_t  result
);

  import fft_pkg::*;

  // full-width product, shifted back to Q8.8 and truncated
  function automatic logic signed [sample_width-1:0] fx_mul(
    input logic signed [sample_width-1:0] a,
    input logic signed [sample_width-1:0] b
  );
    logic signed [2*sample_width-1:0] p;
    p = a * b;
    p = p >>> frac_bits;
    return p[sample_width-1:0];
  endfunction

  always_comb begin : bank
    cplx_t top;
    cplx_t bot;
    cplx_t w;
    cplx_t bw;
    for (int k = 0; k < n_points / 2; k++) begin
      top = data[2*k];
      bot = data[2*k+1];
      w   = twiddles[k];

      // twiddle only the lower input of the pair
      bw.re = fx_mul(bot.re, w.re) - fx_mul(bot.im, w.im);
      bw.im = fx_mul(bot.re, w.im) + fx_mul(bot.im, w.re);

      result[2*k].re   = top.re + bw.re;
      result[2*k].im   = top.im + bw.im;
      result[2*k+1].re = top.re - bw.re;
      result[2*k+1].im = top.im - bw.im;
    end
  end

endmodule

// File: design/fft_pkg.sv
package fft_pkg;

  // Q8.8 real component
  localparam int sample_width = 16;
  localparam int frac_bits = 8;

  localparam int n_points = 8;
  localparam int log_n = 3;

  // one step of the constant-geometry pass
  typedef logic [1:0] stage_t;

  typedef struct packed {
    logic signed [sample_width-1:0] re;
    logic signed [sample_width-1:0] im;
  } cplx_t;

  // element 0 sits in the low bits
  typedef logic signed [n_points-1:0][sample_width-1:0] real_frame_t;

  typedef cplx_t [n_points-1:0] cplx_frame_t;

  // one factor per butterfly
  typedef cplx_t [n_points/2-1:0] twiddle_set_t;

  typedef enum logic [1:0] {
    idle,
    comp,
    done
  } core_state_t;

endpackage

// File: design/pease_fft.sv
`timescale 1ns/1ps

module pease_fft (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic signed [fft_pkg::sample_width-1:0] recv_msg,
  input  logic                                    recv_val,
  output logic                                    recv_rdy,
  output fft_pkg::cplx_t                          send_msg,
  output logic                                    send_val,
  input  logic                                    send_rdy
);

  import fft_pkg::*;

  real_frame_t frame_msg;
  logic        frame_val;
  logic        frame_rdy;
  cplx_frame_t result_msg;
  logic        result_val;
  logic        result_rdy;

  sample_deserializer i_sample_deserializer (
    .clk      (clk),
    .reset    (reset),
    .recv_msg (recv_msg),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .frame_msg(frame_msg),
    .frame_val(frame_val),
    .frame_rdy(frame_rdy)
  );

  pease_fft_core i_pease_fft_core (
    .clk       (clk),
    .reset     (reset),
    .frame_msg (frame_msg),
    .frame_val (frame_val),
    .frame_rdy (frame_rdy),
    .result_msg(result_msg),
    .result_val(result_val),
    .result_rdy(result_rdy)
  );

  sample_serializer i_sample_serializer (
    .clk       (clk),
    .reset     (reset),
    .result_msg(result_msg),
    .result_val(result_val),
    .result_rdy(result_rdy),
    .send_msg  (send_msg),
    .send_val  (send_val),
    .send_rdy  (send_rdy)
  );

endmodule

// File: design/pease_fft_core.sv
`timescale 1ns/1ps

module pease_fft_core (
  input  logic                 clk,
  input  logic                 reset,
  input  fft_pkg::real_frame_t frame_msg,
  input  logic                 frame_val,
  output logic                 frame_rdy,
  output fft_pkg::cplx_frame_t result_msg,
  output logic                 result_val,
  input  logic                 result_rdy
);

  import fft_pkg::*;

  core_state_t  state;
  core_state_t  state_next;
  stage_t       stage;
  cplx_frame_t  stage_q;
  cplx_frame_t  loaded;
  cplx_frame_t  bfly_out;
  cplx_frame_t  shuffled;
  twiddle_set_t twiddles;
  logic         take_frame;
  logic         take_result;
  logic         last_stage;

  function automatic logic [log_n-1:0] bit_rev(input logic [log_n-1:0] idx);
    logic [log_n-1:0] r;
    for (int b = 0; b < log_n; b++) begin
      r[b] = idx[log_n-1-b];
    end
    return r;
  endfunction

  twiddle_rom i_twiddle_rom (
    .stage   (stage),
    .twiddles(twiddles)
  );

  butterfly_bank i_butterfly_bank (
    .data    (stage_q),
    .twiddles(twiddles),
    .result  (bfly_out)
  );

  // one frame at a time, a new one may enter as the result leaves
  assign frame_rdy   = (state == idle) || ((state == done) && result_rdy);
  assign result_val  = (state == done);
  assign result_msg  = stage_q;
  assign take_frame  = frame_val && frame_rdy;
  assign take_result = result_val && result_rdy;
  assign last_stage  = (stage == stage_t'(log_n - 1));

  // bit-reversed load, real input only
  always_comb begin
    for (int i = 0; i < n_points; i++) begin
      loaded[i].re = frame_msg[bit_rev(log_n'(i))];
      loaded[i].im = '0;
    end
  end

  // perfect shuffle of the butterfly outputs
  always_comb begin
    for (int j = 0; j < n_points; j++) begin
      shuffled[(j / 2) + (n_points / 2) * (j % 2)] = bfly_out[j];
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (take_frame) begin
          state_next = comp;
        end
      end
      comp: begin
        if (last_stage) begin
          state_next = done;
        end
      end
      done: begin
        if (take_result) begin
          state_next = take_frame ? comp : idle;
        end
      end
      default: state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      stage <= '0;
    end else begin
      state <= state_next;
      if (state == comp && !last_stage) begin
        stage <= stage + 2'd1;
      end else begin
        stage <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_frame) begin
      stage_q <= loaded;
    end else if (state == comp) begin
      stage_q <= shuffled;
    end
  end

endmodule

// File: design/sample_deserializer.sv
`timescale 1ns/1ps

module sample_deserializer (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic signed [fft_pkg::sample_width-1:0] recv_msg,
  input  logic                                   recv_val,
  output logic                                   recv_rdy,
  output fft_pkg::real_frame_t                   frame_msg,
  output logic                                   frame_val,
  input  logic                                   frame_rdy
);

  import fft_pkg::*;

  logic [2:0] count;
  logic       full;
  logic       take_word;

  // no input while a finished frame waits
  assign recv_rdy  = !full;
  assign frame_val = full;
  assign take_word = recv_val && recv_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      full  <= 1'b0;
    end else begin
      if (take_word) begin
        count <= count + 3'd1;
        // eighth word closes the frame
        if (count == 3'(n_points - 1)) begin
          full <= 1'b1;
        end
      end else if (full && frame_rdy) begin
        full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_word) begin
      frame_msg[count] <= recv_msg;
    end
  end

endmodule

// File: design/sample_serializer.sv
`timescale 1ns/1ps

module sample_serializer (
  input  logic                 clk,
  input  logic                 reset,
  input  fft_pkg::cplx_frame_t result_msg,
  input  logic                 result_val,
  output logic                 result_rdy,
  output fft_pkg::cplx_t       send_msg,
  output logic                 send_val,
  input  logic                 send_rdy
);

  import fft_pkg::*;

  cplx_frame_t frame_q;
  logic [2:0]  bin;
  logic        busy;
  logic        take_result;
  logic        take_beat;

  assign result_rdy  = !busy;
  assign send_val    = busy;
  assign send_msg    = frame_q[bin];
  assign take_result = result_val && result_rdy;
  assign take_beat   = send_val && send_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      bin  <= '0;
    end else begin
      if (take_result) begin
        busy <= 1'b1;
        bin  <= '0;
      end else if (take_beat) begin
        bin <= bin + 3'd1;
        // free again once the last bin leaves
        if (bin == 3'(n_points - 1)) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_result) begin
      frame_q <= result_msg;
    end
  end

endmodule

// File: design/twiddle_rom.sv
`timescale 1ns/1ps

module twiddle_rom (
  input  fft_pkg::stage_t       stage,
  output fft_pkg::twiddle_set_t twiddles
);

  import fft_pkg::*;

  // e^(-2*pi*i*m/8) in Q8.8, cos and -sin rounded
  function automatic cplx_t root(input logic [2:0] m);
    cplx_t w;
    case (m)
      3'd0: begin w.re = 16'sd256;  w.im = 16'sd0;    end
      3'd1: begin w.re = 16'sd181;  w.im = -16'sd181; end
      3'd2: begin w.re = 16'sd0;    w.im = -16'sd256; end
      3'd3: begin w.re = -16'sd181; w.im = -16'sd181; end
      3'd4: begin w.re = -16'sd256; w.im = 16'sd0;    end
      3'd5: begin w.re = -16'sd181; w.im = 16'sd181;  end
      3'd6: begin w.re = 16'sd0;    w.im = 16'sd256;  end
      default: begin
        w.re = 16'sd181;
        w.im = 16'sd181;
      end
    endcase
    return w;
  endfunction

  always_comb begin : select
    logic [1:0] mask;
    logic [1:0] k_bits;
    logic [2:0] m;
    // stage s keeps only the top s bits of the butterfly index
    mask = 2'(2'b11 << (2'(log_n - 1) - stage));
    for (int k = 0; k < n_points / 2; k++) begin
      k_bits = 2'(k);
      m = {1'b0, k_bits & mask};
      twiddles[k] = root(m);
    end
  end

endmodule

// File: list.f
design/fft_pkg.sv
design/sample_deserializer.sv
design/twiddle_rom.sv
design/butterfly_bank.sv
design/pease_fft_core.sv
design/sample_serializer.sv
design/pease_fft.sv
sim/clock_gen.sv
sim/fft_checker.sv
sim/pease_fft_tb.sv

// File: sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ten cycles of reset, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// File: sim/fft_checker.sv
`timescale 1ns/1ps

module fft_checker (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 recv_val,
  input  logic                 recv_rdy,
  input  fft_pkg::cplx_t       send_msg,
  input  logic                 send_val,
  input  logic                 send_rdy,
  input  logic                 push,
  input  fft_pkg::real_frame_t push_frame,
  input  logic                 push_exact,
  input  fft_pkg::real_frame_t push_expect,
  output int                   value_errors,
  output int                   other_errors,
  output int                   frames_done
);

  import fft_pkg::*;

  localparam real pi = 3.14159265358979;
  localparam real tolerance = 4.0;

  typedef struct packed {
    logic        exact;
    real_frame_t expect_re;
    real_frame_t samples;
  } pending_t;

  pending_t pending_q[$];
  pending_t cur;
  logic     have_frame;
  logic     reset_q;
  int       bin;
  int       words_in;
  int       frames_in;

  // direct DFT, one component of bin k, in LSB units
  function automatic real dft_part(input real_frame_t x, input int k, input bit imag);
    real acc;
    real ang;
    acc = 0.0;
    for (int n = 0; n < n_points; n++) begin
      ang = 2.0 * pi * real'(k * n) / real'(n_points);
      if (imag) begin
        acc = acc - real'($signed(x[n])) * $sin(ang);
      end else begin
        acc = acc + real'($signed(x[n])) * $cos(ang);
      end
    end
    return acc;
  endfunction

  task automatic compare_part(input string name, input int idx, input real ref_val,
                              input logic signed [sample_width-1:0] actual);
    real diff;
    logic signed [sample_width-1:0] expect_hex;
    diff = real'(actual) - ref_val;
    if (diff > tolerance || diff < -tolerance) begin
      expect_hex = 16'($rtoi(ref_val >= 0.0 ? ref_val + 0.5 : ref_val - 0.5));
      $display("ERR %s bin %0d: expected %h actual %h", name, idx, expect_hex, actual);
      value_errors++;
    end
  endtask

  always @(posedge clk) begin
    reset_q <= reset;
    if (reset) begin
      pending_q.delete();
      bin          = 0;
      words_in     = 0;
      frames_in    = 0;
      have_frame   = 1'b0;
      value_errors = 0;
      other_errors = 0;
      frames_done  = 0;
    end else begin
      // first cycle out of reset
      if (reset_q && send_val !== 1'b0) begin
        $display("ERR send_val after reset: expected %h actual %h", 1'b0, send_val);
        value_errors++;
      end
      if (reset_q && recv_rdy !== 1'b1) begin
        $display("ERR recv_rdy after reset: expected %h actual %h", 1'b1, recv_rdy);
        value_errors++;
      end
      // deserializer, core and serializer each hold a frame
      if (frames_in - frames_done >= 3 && recv_rdy !== 1'b0) begin
        $display("ERR recv_rdy with three frames in flight: expected %h actual %h",
                 1'b0, recv_rdy);
        value_errors++;
      end
      if (recv_val && recv_rdy) begin
        if (words_in == n_points - 1) begin
          words_in = 0;
          frames_in++;
        end else begin
          words_in++;
        end
      end
      if (push) begin
        pending_q.push_back('{push_exact, push_expect, push_frame});
      end
      if (send_val && send_rdy) begin
        if (bin == 0) begin
          have_frame = (pending_q.size() != 0);
          if (have_frame) begin
            cur = pending_q.pop_front();
          end else begin
            $display("an output frame started but no input frame was outstanding");
            other_errors++;
          end
        end
        if (have_frame) begin
          compare_part("send_msg.re", bin, dft_part(cur.samples, bin, 1'b0), send_msg.re);
          compare_part("send_msg.im", bin, dft_part(cur.samples, bin, 1'b1), send_msg.im);
          // table frames also have an exact spectrum
          if (cur.exact && send_msg.re !== cur.expect_re[bin]) begin
            $display("ERR send_msg.re bin %0d: expected %h actual %h",
                     bin, cur.expect_re[bin], send_msg.re);
            value_errors++;
          end
          if (cur.exact && send_msg.im !== 16'sd0) begin
            $display("ERR send_msg.im bin %0d: expected %h actual %h", bin, 16'h0, send_msg.im);
            value_errors++;
          end
        end
        if (bin == n_points - 1) begin
          bin = 0;
          frames_done++;
        end else begin
          bin++;
        end
      end
    end
  end

endmodule

// File: sim/pease_fft_tb.sv
`timescale 1ns/1ps

module pease_fft_tb;

  import fft_pkg::*;

  localparam int n_table = 5;
  localparam int n_random = 20;
  localparam int wait_limit = 500;

  logic                    clk;
  logic                    reset;
  logic signed [sample_width-1:0] recv_msg;
  logic                    recv_val;
  logic                    recv_rdy;
  cplx_t                   send_msg;
  logic                    send_val;
  logic                    send_rdy;
  logic                    push;
  real_frame_t             push_frame;
  logic                    push_exact;
  real_frame_t             push_expect;
  int                      value_errors;
  int                      other_errors;
  int                      frames_done;
  int                      frames_sent;
  int                      tb_errors;
  int                      ready_mode;
  bit                      timed_out;

  // impulse, constant, zeros, alternating sign, cosine at bin 2
  int stim_tab [n_table][n_points] = '{
    '{256, 0, 0, 0, 0, 0, 0, 0},
    '{64, 64, 64, 64, 64, 64, 64, 64},
    '{0, 0, 0, 0, 0, 0, 0, 0},
    '{128, -128, 128, -128, 128, -128, 128, -128},
    '{128, 0, -128, 0, 128, 0, -128, 0}
  };

  // real part of each bin, all imaginary parts zero
  int expect_tab [n_table][n_points] = '{
    '{256, 256, 256, 256, 256, 256, 256, 256},
    '{512, 0, 0, 0, 0, 0, 0, 0},
    '{0, 0, 0, 0, 0, 0, 0, 0},
    '{0, 0, 0, 0, 1024, 0, 0, 0},
    '{0, 0, 512, 0, 0, 0, 512, 0}
  };

  clock_gen i_clock_gen (
    .clk  (clk),
    .reset(reset)
  );

  pease_fft i_pease_fft (
    .clk     (clk),
    .reset   (reset),
    .recv_msg(recv_msg),
    .recv_val(recv_val),
    .recv_rdy(recv_rdy),
    .send_msg(send_msg),
    .send_val(send_val),
    .send_rdy(send_rdy)
  );

  fft_checker i_fft_checker (
    .clk         (clk),
    .reset       (reset),
    .recv_val    (recv_val),
    .recv_rdy    (recv_rdy),
    .send_msg    (send_msg),
    .send_val    (send_val),
    .send_rdy    (send_rdy),
    .push        (push),
    .push_frame  (push_frame),
    .push_exact  (push_exact),
    .push_expect (push_expect),
    .value_errors(value_errors),
    .other_errors(other_errors),
    .frames_done (frames_done)
  );

  // 0 always ready, 1 random, 2 stalled
  task automatic drive_ready();
    forever begin
      @(negedge clk);
      case (ready_mode)
        1: send_rdy = 1'($urandom_range(1));
        2: send_rdy = 1'b0;
        default: send_rdy = 1'b1;
      endcase
    end
  endtask

  task automatic wait_reset();
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (reset) begin
      if (cnt == wait_limit) begin
        $display("timeout: reset was never released");
        timed_out = 1'b1;
        return;
      end
      @(negedge clk);
      cnt++;
    end
  endtask

  task automatic send_frame(input real_frame_t frame, input logic exact,
                            input real_frame_t expect_re);
    int cnt;
    if (timed_out) return;
    for (int i = 0; i < n_points; i++) begin
      @(negedge clk);
      push     = 1'b0;
      recv_val = 1'b1;
      recv_msg = frame[i];
      cnt = 0;
      while (!recv_rdy) begin
        if (cnt == wait_limit) begin
          $display("timeout: word %0d of frame %0d was never accepted", i, frames_sent);
          timed_out = 1'b1;
          return;
        end
        @(negedge clk);
        cnt++;
      end
      // word 0 transfers on the coming edge, queue the frame with it
      if (i == 0) begin
        push        = 1'b1;
        push_frame  = frame;
        push_exact  = exact;
        push_expect = expect_re;
      end
    end
    frames_sent++;
  endtask

  task automatic end_input();
    @(negedge clk);
    recv_val = 1'b0;
    push     = 1'b0;
  endtask

  task automatic wait_input_blocked();
    int cnt;
    if (timed_out) return;
    cnt = 0;
    while (recv_rdy) begin
      if (cnt == wait_limit) begin
        $display("timeout: input stayed ready with three frames in flight");
        timed_out = 1'b1;
        return;
      end
      @(negedge clk);
      cnt++;
    end
  endtask

  task automatic wait_drain();
    int cnt;
    if (timed_out) return;
    cnt = 0;
    while (frames_done != frames_sent) begin
      if (cnt == wait_limit) begin
        $display("timeout: only %0d of %0d frames came out", frames_done, frames_sent);
        timed_out = 1'b1;
        return;
      end
      @(negedge clk);
      cnt++;
    end
  endtask

  // magnitude at most 0.5 in Q8.8
  function automatic real_frame_t random_frame();
    real_frame_t f;
    for (int i = 0; i < n_points; i++) begin
      f[i] = 16'(int'($urandom_range(256)) - 128);
    end
    return f;
  endfunction

  initial begin
    real_frame_t f;
    real_frame_t e;
    void'($urandom(98));
    recv_msg    = '0;
    recv_val    = 1'b0;
    send_rdy    = 1'b1;
    push        = 1'b0;
    push_frame  = '0;
    push_exact  = 1'b0;
    push_expect = '0;
    ready_mode  = 0;
    frames_sent = 0;
    tb_errors   = 0;
    timed_out   = 1'b0;
    fork
      drive_ready();
    join_none
    wait_reset();

    for (int r = 0; r < n_table; r++) begin
      for (int i = 0; i < n_points; i++) begin
        f[i] = 16'(stim_tab[r][i]);
        e[i] = 16'(expect_tab[r][i]);
      end
      send_frame(f, 1'b1, e);
    end
    end_input();
    wait_drain();

    // random frames against random output back-pressure
    ready_mode = 1;
    for (int r = 0; r < n_random; r++) begin
      send_frame(random_frame(), 1'b0, '0);
    end
    end_input();
    wait_drain();

    // stalled output, three frames fill the chain
    ready_mode = 2;
    for (int r = 0; r < 3; r++) begin
      send_frame(random_frame(), 1'b0, '0);
    end
    end_input();
    wait_input_blocked();
    ready_mode = 0;
    send_frame(random_frame(), 1'b0, '0);
    end_input();
    wait_drain();

    if (timed_out) begin
      tb_errors++;
    end
    $display("errors: value %0d, other %0d, testbench %0d; frames checked %0d of %0d",
             value_errors, other_errors, tb_errors, frames_done, frames_sent);
    if (value_errors == 0 && other_errors == 0 && tb_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
